/* bench/corr_checker.sv */
//########################################
// correlator checker
// reference model of the counts
// uart decoder, packet and busy checks
//########################################

`default_nettype none

`include "corr_settings.svh"

module corr_checker
	import corr_pkg::*;
(
	input wire intclk,
	input wire rst_n,
	input wire sample_t line_in,
	input wire sample_t invert_mask,
	input wire integrate,
	input wire tx,
	input wire busy,
	input wire idle_check,
	output int errors,
	output int frames,
	output int pending,
	output int rx_bytes
);

	int div;
	int smp_n;
	int frame_no;
	int cnt [`CORR_NUM_CNT];
	sample_t smp;  // last captured sample, used on the next tick
	sample_t hist [`CORR_LAGS];
	logic [7:0] exp_q [$];
	logic rx_on;
	int rx_ph;
	logic [7:0] rx_byte;

	function automatic logic [7:0] hex_ascii(input int nib);
		string digits;
		digits = "0123456789ABCDEF";
		return digits.getc(nib);
	endfunction

	task automatic clear_model();
		foreach (cnt[i]) cnt[i] = 0;
		foreach (hist[g]) hist[g] = '0;
		smp_n = 0;
		frame_no = 0;
	endtask

	task automatic queue_packet();
		exp_q.push_back(8'h3c);
		foreach (cnt[i]) begin
			for (int n = `CORR_RES / 4 - 1; n >= 0; n--) begin
				exp_q.push_back(hex_ascii((cnt[i] >> (4 * n)) & 15));  // MS nibble first
			end
		end
		exp_q.push_back(hex_ascii(frame_no / 16));
		exp_q.push_back(hex_ascii(frame_no % 16));
		exp_q.push_back(8'h3e);
		frames++;
	endtask

	task automatic take_sample();
		int k;
		k = `CORR_LINES * (`CORR_LAGS + 1);  // first cross counter
		for (int a = 0; a < `CORR_LINES; a++) begin
			cnt[a] += int'(smp[a]);
			for (int g = 0; g < `CORR_LAGS; g++) begin
				cnt[`CORR_LINES + a * `CORR_LAGS + g] += int'(smp[a] == hist[g][a]);
			end
			for (int b = a + 1; b < `CORR_LINES; b++) begin
				cnt[k] += int'(smp[a] == smp[b]);
				k++;
			end
		end
		for (int g = `CORR_LAGS - 1; g > 0; g--) begin
			hist[g] = hist[g - 1];
		end
		hist[0] = smp;
		smp_n++;
		if (smp_n == `CORR_FRAME) begin
			queue_packet();
			foreach (cnt[i]) cnt[i] = 0;
			smp_n = 0;
			frame_no = (frame_no + 1) % 256;
		end
	endtask

	// bit i of a byte covers phases 4i..4i+3, looked at in the middle
	task automatic decode_tx();
		logic [7:0] want;
		if (!rx_on) begin
			rx_on = (tx === 1'b0);
			rx_ph = 0;
		end else begin
			rx_ph++;
			if (busy !== 1'b1) begin
				errors++;
				$display("ERR %0t busy expected 1 actual %b", $time, busy);
			end
			if (rx_ph == 2 && tx !== 1'b0) begin
				errors++;
				rx_on = 1'b0;
				$display("%0t: start bit on tx did not last half a bit", $time);
			end else if (rx_ph % 4 == 2 && rx_ph > 2 && rx_ph < 38) begin
				rx_byte = {tx, rx_byte[7:1]};  // lsb first
			end else if (rx_ph == 38) begin
				rx_on = 1'b0;
				if (tx !== 1'b1) begin
					errors++;
					$display("%0t: no stop bit after tx byte %0d", $time, rx_bytes);
				end
				if (exp_q.size() == 0) begin
					errors++;
					$display("%0t: byte %02h came out on tx with no packet expected",
						$time, rx_byte);
				end else begin
					want = exp_q.pop_front();
					if (want !== rx_byte) begin
						errors++;
						$display("ERR %0t tx byte %0d expected %02h actual %02h",
							$time, rx_bytes, want, rx_byte);
					end
				end
				rx_bytes++;
			end
		end
	endtask

	// inputs move just after the rising edge, so the falling edge sees what the DUT will take
	always @(negedge intclk) begin
		if (!rst_n) begin
			div = 0;
			smp = '0;
			rx_on = 1'b0;
			clear_model();
		end else begin
			if (!integrate) begin
				clear_model();
			end else if (div == `CORR_SMP_DIV - 1) begin
				take_sample();
			end
			if (div == `CORR_SMP_DIV - 1) begin
				smp = line_in ^ invert_mask;
				div = 0;
			end else begin
				div++;
			end
			decode_tx();
		end
		if (idle_check && tx !== 1'b1) begin
			errors++;
			$display("ERR %0t tx expected 1 actual %b", $time, tx);
		end
		if (idle_check && busy !== 1'b0) begin
			errors++;
			$display("ERR %0t busy expected 0 actual %b", $time, busy);
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

/* bench/tb_corr.sv */
//########################################
// correlator testbench top
// clock, reset, LCG stimulus, watchdog
// DUT and checker instances, test sequence
//########################################

`default_nettype none

`include "corr_settings.svh"

module tb_corr
	import corr_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int FRAME_CYCLES = `CORR_FRAME * `CORR_SMP_DIV;
	localparam int PACKET_CYCLES = 76 * 11 * `CORR_BAUD_DIV;  // bytes plus handoff gaps
	localparam int WATCHDOG_CYCLES = 6 * 3 * FRAME_CYCLES + RESET_CYCLES + 8 * PACKET_CYCLES;

	logic intclk = 1'b0;
	logic rst_n;
	logic integrate;
	logic idle_check;
	sample_t line_in;
	sample_t invert_mask;
	logic tx;
	logic busy;
	logic [31:0] seed = 32'h9420bf5f;
	int errors;
	int frames;
	int pending;
	int rx_bytes;
	int err_mark;
	int frame_mark;
	int test_no;

	always #5 intclk = ~intclk;

	corr_top i_corr_top (
		.intclk(intclk), .rst_n(rst_n),
		.line_in(line_in), .invert_mask(invert_mask), .integrate(integrate),
		.tx(tx), .busy(busy)
	);

	corr_checker i_checker (
		.intclk(intclk), .rst_n(rst_n),
		.line_in(line_in), .invert_mask(invert_mask), .integrate(integrate),
		.tx(tx), .busy(busy), .idle_check(idle_check),
		.errors(errors), .frames(frames), .pending(pending), .rx_bytes(rx_bytes)
	);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic next_cycle();
		@(posedge intclk);
		#1;
	endtask

	// mode 0 holds the lines, 2 ties line 1 to line 0 and line 3 to ~line 2
	task automatic drive_lines(input int mode);
		logic [31:0] r;
		r = lcg_next();
		if (mode == 1) begin
			line_in = r[31:28];  // upper LCG bits have the longer period
		end else if (mode == 2) begin
			line_in = {~r[30], r[30], r[29], r[29]};
		end
	endtask

	task automatic start_run(input sample_t lines, input sample_t mask);
		integrate = 1'b0;
		line_in = lines;
		invert_mask = mask;
		repeat (2 * `CORR_SMP_DIV) next_cycle();
	endtask

	task automatic run_frames(input int n, input int mode);
		int target;
		target = frames + n;
		integrate = 1'b1;
		while (frames < target) begin
			next_cycle();
			drive_lines(mode);
		end
		integrate = 1'b0;
	endtask

	task automatic drain();
		while (pending != 0 || busy) begin
			next_cycle();
		end
	endtask

	task automatic finish_test(input string name);
		test_no++;
		$display("test %0d %s: %0d frames, %0d errors", test_no, name,
			frames - frame_mark, errors - err_mark);
		err_mark = errors;
		frame_mark = frames;
	endtask

	initial begin
		logic [31:0] rnd;
		rst_n = 1'b0;
		integrate = 1'b0;
		idle_check = 1'b0;
		line_in = '0;
		invert_mask = '0;
		err_mark = 0;
		frame_mark = 0;
		test_no = 0;
		repeat (RESET_CYCLES) next_cycle();
		rst_n = 1'b1;

		idle_check = 1'b1;
		repeat (300) next_cycle();
		idle_check = 1'b0;
		finish_test("idle");

		start_run(4'hf, 4'h0);
		run_frames(1, 0);
		drain();
		start_run(4'hf, 4'h5);
		run_frames(1, 0);
		drain();
		start_run(4'h3, 4'ha);
		run_frames(1, 0);
		drain();
		finish_test("polarity");

		start_run(4'h0, 4'h0);
		run_frames(3, 1);  // history runs on across frame edges
		drain();
		finish_test("auto lags");

		start_run(4'h0, 4'h3);  // pair 01 stays equal, pair 23 stays opposite
		run_frames(2, 2);
		drain();
		finish_test("cross");

		start_run(4'h0, 4'h0);
		run_frames(2, 1);
		repeat (20) next_cycle();  // numbering restarts while a packet is still going out
		run_frames(2, 1);
		drain();
		finish_test("framing");

		rnd = lcg_next();
		start_run(4'h0, rnd[27:24]);
		run_frames(3, 1);
		drain();
		finish_test("long random");

		$display("%0d tests, %0d packets, %0d bytes, %0d errors", test_no, frames,
			rx_bytes, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge intclk);
		if (pending != 0) begin
			$display("watchdog: %0d expected bytes never came out on tx", pending);
		end else begin
			$display("watchdog: test sequence stalled");
		end
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* corr.f */
+incdir+src
src/corr_pkg.sv
src/line_sampler.sv
src/correlator_core.sv
src/packet_builder.sv
src/uart_tx.sv
src/corr_top.sv
bench/corr_checker.sv
bench/tb_corr.sv

/* run_corr.sh */
#!/bin/sh
# compile the correlator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_corr -f corr.f || exit 1
out=$(./obj_dir/Vtb_corr)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

/* src/corr_pkg.sv */
//########################################
// correlator types
// sample, counter, counter bank, frame number
// packet builder FSM states
//########################################

`default_nettype none

`include "corr_settings.svh"

package corr_pkg;

	typedef logic [`CORR_LINES-1:0] sample_t;
	typedef logic [`CORR_RES-1:0] count_t;

	// counter 0 sits in the top bits, so the bank reads out MSB first
	typedef logic [`CORR_NUM_CNT*`CORR_RES-1:0] cnt_bank_t;

	typedef logic [7:0] frame_num_t;

	typedef enum logic [2:0] {
		idle,
		send_start,
		send_hex,
		send_frame,
		send_end
	} builder_state_t;

endpackage

`default_nettype wire

/* src/corr_settings.svh */
//########################################
// correlator build constants
// line count, auto lags, counter width
// sample divisor, frame length, baud divisor
//########################################

`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

`define CORR_LINES 4        // one-bit input lines
`define CORR_LAGS 2         // auto lags 1..CORR_LAGS

`define CORR_RES 16         // bits per counter

`define CORR_SMP_DIV 4      // intclk cycles per sample tick
`define CORR_FRAME 1024     // samples per frame

`define CORR_BAUD_DIV 4     // intclk cycles per uart bit

// ones + auto + cross pairs
`define CORR_NUM_CNT (`CORR_LINES + `CORR_LINES * `CORR_LAGS + \
	`CORR_LINES * (`CORR_LINES - 1) / 2)

`endif

/* src/corr_top.sv */
//########################################
// correlator top level
// sampler, core, packet builder, uart
//########################################

`default_nettype none

module corr_top
	import corr_pkg::*;
(
	input wire intclk,
	input wire rst_n,
	input wire sample_t line_in,
	input wire sample_t invert_mask,
	input wire integrate,
	output logic tx,
	output logic busy
);

	sample_t sample;
	logic sample_tick;
	cnt_bank_t counts;
	frame_num_t frame_num;
	logic frame_end;
	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	line_sampler i_sampler (
		.intclk(intclk), .rst_n(rst_n),
		.line_in(line_in), .invert_mask(invert_mask),
		.sample(sample), .sample_tick(sample_tick)
	);

	correlator_core i_core (
		.intclk(intclk), .rst_n(rst_n), .integrate(integrate),
		.sample(sample), .sample_tick(sample_tick),
		.counts(counts), .frame_num(frame_num), .frame_end(frame_end)
	);

	packet_builder i_builder (
		.intclk(intclk), .rst_n(rst_n),
		.counts(counts), .frame_num(frame_num), .frame_end(frame_end),
		.tx_busy(tx_busy), .tx_byte(tx_byte), .tx_start(tx_start), .busy(busy)
	);

	uart_tx i_uart (
		.intclk(intclk), .rst_n(rst_n),
		.tx_byte(tx_byte), .tx_start(tx_start),
		.tx(tx), .tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

/* src/correlator_core.sv */
//########################################
// correlator processing
// lag history, ones, auto and cross counters
// sample and frame counting
// end-of-frame snapshot and strobe
//########################################

`default_nettype none

`include "corr_settings.svh"

module correlator_core
	import corr_pkg::*;
(
	input wire intclk,
	input wire rst_n,
	input wire integrate,
	input wire sample_t sample,
	input wire sample_tick,
	output cnt_bank_t counts,
	output frame_num_t frame_num,
	output logic frame_end
);

	localparam int ONES_BASE = 0;
	localparam int AUTO_BASE = ONES_BASE + `CORR_LINES;
	localparam int CROSS_BASE = AUTO_BASE + `CORR_LINES * `CORR_LAGS;
	localparam int SMP_W = $clog2(`CORR_FRAME);

	sample_t hist [`CORR_LAGS];  // hist[g] is the sample g+1 ticks back
	count_t cnt [`CORR_NUM_CNT];
	count_t nxt [`CORR_NUM_CNT];
	logic [`CORR_NUM_CNT-1:0] hit;
	logic [SMP_W-1:0] smp_cnt;
	frame_num_t frame_cnt;
	logic frame_done;

	assign frame_done = integrate && sample_tick && (smp_cnt == SMP_W'(`CORR_FRAME - 1));

	// one increment bit per counter for the current sample
	always_comb begin
		int k;
		k = CROSS_BASE;
		for (int l = 0; l < `CORR_LINES; l++) begin
			hit[ONES_BASE + l] = sample[l];
			for (int g = 0; g < `CORR_LAGS; g++) begin
				hit[AUTO_BASE + l * `CORR_LAGS + g] = ~(sample[l] ^ hist[g][l]);
			end
		end
		for (int a = 0; a < `CORR_LINES - 1; a++) begin
			for (int b = a + 1; b < `CORR_LINES; b++) begin
				hit[k] = ~(sample[a] ^ sample[b]);  // pairs 01, 02, 03, 12 ...
				k++;
			end
		end
		for (int i = 0; i < `CORR_NUM_CNT; i++) begin
			if (hit[i] && cnt[i] != '1) begin
				nxt[i] = cnt[i] + 1'b1;
			end else begin
				nxt[i] = cnt[i];  // holds at full scale
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (!rst_n || !integrate) begin
			for (int i = 0; i < `CORR_NUM_CNT; i++) begin
				cnt[i] <= '0;
			end
			for (int g = 0; g < `CORR_LAGS; g++) begin
				hist[g] <= '0;
			end
			smp_cnt <= '0;
			frame_cnt <= '0;
		end else if (sample_tick) begin
			hist[0] <= sample;
			for (int g = 1; g < `CORR_LAGS; g++) begin
				hist[g] <= hist[g-1];
			end
			if (frame_done) begin
				for (int i = 0; i < `CORR_NUM_CNT; i++) begin
					cnt[i] <= '0;
				end
				smp_cnt <= '0;
				frame_cnt <= frame_cnt + 1'b1;  // wraps at 256
			end else begin
				cnt <= nxt;
				smp_cnt <= smp_cnt + 1'b1;
			end
		end
	end

	// final counts include the last sample of the frame
	always_ff @(posedge intclk) begin
		if (frame_done) begin
			for (int i = 0; i < `CORR_NUM_CNT; i++) begin
				counts[(`CORR_NUM_CNT-1-i)*`CORR_RES +: `CORR_RES] <= nxt[i];
			end
			frame_num <= frame_cnt;
		end
	end

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			frame_end <= 1'b0;
		end else begin
			frame_end <= frame_done;
		end
	end

endmodule

`default_nettype wire

/* src/line_sampler.sv */
//########################################
// input side of the correlator
// sample tick divider
// polarity inversion and sample register
//########################################

`default_nettype none

`include "corr_settings.svh"

module line_sampler
	import corr_pkg::*;
(
	input wire intclk,
	input wire rst_n,
	input wire sample_t line_in,
	input wire sample_t invert_mask,
	output sample_t sample,
	output logic sample_tick
);

	localparam int DIV_W = $clog2(`CORR_SMP_DIV);

	logic [DIV_W-1:0] div_cnt;

	assign sample_tick = (div_cnt == DIV_W'(`CORR_SMP_DIV - 1));

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (sample_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// the core sees this one tick later
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			sample <= '0;
		end else if (sample_tick) begin
			sample <= line_in ^ invert_mask;  // mask bit set flips the line
		end
	end

endmodule

`default_nettype wire

/* src/packet_builder.sv */
//########################################
// packet builder FSM
// latches counters and frame number
// emits '<', hex counters, hex frame, '>'
//########################################

`default_nettype none

`include "corr_settings.svh"

module packet_builder
	import corr_pkg::*;
(
	input wire intclk,
	input wire rst_n,
	input wire cnt_bank_t counts,
	input wire frame_num_t frame_num,
	input wire frame_end,
	input wire tx_busy,
	output logic [7:0] tx_byte,
	output logic tx_start,
	output logic busy
);

	localparam int NIBS = `CORR_NUM_CNT * `CORR_RES / 4;
	localparam int NIB_W = $clog2(NIBS);

	builder_state_t state;
	cnt_bank_t bank;
	frame_num_t frm;
	logic [NIB_W-1:0] nib_cnt;
	logic ready;

	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return 8'h30 + {4'h0, nib};
		end
		return 8'h37 + {4'h0, nib};  // 'A' for 10
	endfunction

	assign ready = !tx_busy && !tx_start;  // last start already taken by the uart
	assign busy = (state != idle) || tx_busy || tx_start;

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			state <= idle;
			tx_start <= 1'b0;
			nib_cnt <= '0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				idle: if (frame_end) begin  // frames arriving mid-packet are dropped
					bank <= counts;
					frm <= frame_num;
					nib_cnt <= '0;
					state <= send_start;
				end
				send_start: if (ready) begin
					tx_byte <= 8'h3c;
					tx_start <= 1'b1;
					state <= send_hex;
				end
				send_hex: if (ready) begin
					tx_byte <= hex_char(bank[$bits(bank)-1 -: 4]);
					tx_start <= 1'b1;
					bank <= bank << 4;
					nib_cnt <= nib_cnt + 1'b1;
					if (nib_cnt == NIB_W'(NIBS - 1)) begin
						nib_cnt <= '0;
						state <= send_frame;
					end
				end
				send_frame: if (ready) begin
					tx_byte <= hex_char(frm[7:4]);
					tx_start <= 1'b1;
					frm <= frm << 4;
					nib_cnt <= nib_cnt + 1'b1;
					if (nib_cnt == NIB_W'(1)) begin
						state <= send_end;
					end
				end
				send_end: if (ready) begin
					tx_byte <= 8'h3e;
					tx_start <= 1'b1;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/uart_tx.sv */
//########################################
// 8N1 uart transmitter
// fixed bit period, busy level
//########################################

`default_nettype none

`include "corr_settings.svh"

module uart_tx (
	input wire intclk,
	input wire rst_n,
	input wire [7:0] tx_byte,
	input wire tx_start,
	output logic tx,
	output logic tx_busy
);

	localparam int BAUD_W = $clog2(`CORR_BAUD_DIV);

	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [8:0] shreg;  // data bits then stop

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				shreg <= {1'b1, tx_byte};
				tx <= 1'b0;  // start bit
				tx_busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (baud_cnt == BAUD_W'(`CORR_BAUD_DIV - 1)) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;  // stop bit done
			end else begin
				tx <= shreg[0];
				shreg <= {1'b0, shreg[8:1]};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire
